/* project.f */
+incdir+.
rv_isa_pkg.sv
rv_decode_pkg.sv
rv_inst_decoder.sv
rv_id_ex_reg.sv
rv_operand_builder.sv
rv_decode_stage.sv
rv_decode_asserts.sv
tb_rv_decode.sv

/* tb_rv_decode.sv */
/* random-stimulus testbench for the decode stage, checks every valid item
   against a reference model one cycle after it is driven */
`include "rv_defines.svh"

module tb_rv_decode
  import rv_isa_pkg::*;
  import rv_decode_pkg::*;
();

  localparam int n_tests = 2000;
  // bit 30 value from the table, 2 leaves it random
  localparam logic [1:0] b30_any = 2'd2;

  typedef struct packed {
    rv_fmt_e    fmt;
    logic [6:0] opc;
    logic [2:0] f3;
    logic [1:0] b30;
  } enc_t;

  logic                clk;
  logic                rst;
  logic                i_valid;
  logic [`RV_ILEN-1:0] i_inst;
  logic [`RV_XLEN-1:0] i_pc;
  logic [`RV_XLEN-1:0] i_rs1_data;
  logic [`RV_XLEN-1:0] i_rs2_data;
  logic                o_valid;
  rv_exec_t            o_exec;

  // one-deep delay of the expectation
  logic                pend_v;
  rv_exec_t            pend;

  rv_decode_stage dut0 (
    .clk        (clk),
    .rst        (rst),
    .i_valid    (i_valid),
    .i_inst     (i_inst),
    .i_pc       (i_pc),
    .i_rs1_data (i_rs1_data),
    .i_rs2_data (i_rs2_data),
    .o_valid    (o_valid),
    .o_exec     (o_exec)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // ISA encoding of each kept instruction
  function automatic enc_t op_encoding(input rv_op_e op);
    enc_t e;
    case (op)
      OP_LUI:     e = '{FMT_U, `RV_OPC_LUI, 3'd0, b30_any};
      OP_AUIPC:   e = '{FMT_U, `RV_OPC_AUIPC, 3'd0, b30_any};
      OP_JAL:     e = '{FMT_J, `RV_OPC_JAL, 3'd0, b30_any};
      OP_JALR:    e = '{FMT_I, `RV_OPC_JALR, 3'd0, b30_any};
      OP_BEQ:     e = '{FMT_B, `RV_OPC_BRANCH, 3'd0, b30_any};
      OP_BNE:     e = '{FMT_B, `RV_OPC_BRANCH, 3'd1, b30_any};
      OP_BLT:     e = '{FMT_B, `RV_OPC_BRANCH, 3'd4, b30_any};
      OP_BGE:     e = '{FMT_B, `RV_OPC_BRANCH, 3'd5, b30_any};
      OP_BLTU:    e = '{FMT_B, `RV_OPC_BRANCH, 3'd6, b30_any};
      OP_BGEU:    e = '{FMT_B, `RV_OPC_BRANCH, 3'd7, b30_any};
      OP_LB:      e = '{FMT_I, `RV_OPC_LOAD, 3'd0, b30_any};
      OP_LH:      e = '{FMT_I, `RV_OPC_LOAD, 3'd1, b30_any};
      OP_LW:      e = '{FMT_I, `RV_OPC_LOAD, 3'd2, b30_any};
      OP_LD:      e = '{FMT_I, `RV_OPC_LOAD, 3'd3, b30_any};
      OP_LBU:     e = '{FMT_I, `RV_OPC_LOAD, 3'd4, b30_any};
      OP_LHU:     e = '{FMT_I, `RV_OPC_LOAD, 3'd5, b30_any};
      OP_LWU:     e = '{FMT_I, `RV_OPC_LOAD, 3'd6, b30_any};
      OP_SB:      e = '{FMT_S, `RV_OPC_STORE, 3'd0, b30_any};
      OP_SH:      e = '{FMT_S, `RV_OPC_STORE, 3'd1, b30_any};
      OP_SW:      e = '{FMT_S, `RV_OPC_STORE, 3'd2, b30_any};
      OP_SD:      e = '{FMT_S, `RV_OPC_STORE, 3'd3, b30_any};
      OP_ADDI:    e = '{FMT_I, `RV_OPC_OPIMM, 3'd0, b30_any};
      OP_SLTI:    e = '{FMT_I, `RV_OPC_OPIMM, 3'd2, b30_any};
      OP_SLTIU:   e = '{FMT_I, `RV_OPC_OPIMM, 3'd3, b30_any};
      OP_XORI:    e = '{FMT_I, `RV_OPC_OPIMM, 3'd4, b30_any};
      OP_ORI:     e = '{FMT_I, `RV_OPC_OPIMM, 3'd6, b30_any};
      OP_ANDI:    e = '{FMT_I, `RV_OPC_OPIMM, 3'd7, b30_any};
      OP_SLLI:    e = '{FMT_I, `RV_OPC_OPIMM, 3'd1, b30_any};
      OP_SRLI:    e = '{FMT_I, `RV_OPC_OPIMM, 3'd5, 2'd0};
      OP_SRAI:    e = '{FMT_I, `RV_OPC_OPIMM, 3'd5, 2'd1};
      OP_ADD:     e = '{FMT_R, `RV_OPC_OP, 3'd0, 2'd0};
      OP_SUB:     e = '{FMT_R, `RV_OPC_OP, 3'd0, 2'd1};
      OP_SLL:     e = '{FMT_R, `RV_OPC_OP, 3'd1, b30_any};
      OP_SLT:     e = '{FMT_R, `RV_OPC_OP, 3'd2, b30_any};
      OP_SLTU:    e = '{FMT_R, `RV_OPC_OP, 3'd3, b30_any};
      OP_XOR:     e = '{FMT_R, `RV_OPC_OP, 3'd4, b30_any};
      OP_SRL:     e = '{FMT_R, `RV_OPC_OP, 3'd5, 2'd0};
      OP_SRA:     e = '{FMT_R, `RV_OPC_OP, 3'd5, 2'd1};
      OP_OR:      e = '{FMT_R, `RV_OPC_OP, 3'd6, b30_any};
      OP_AND:     e = '{FMT_R, `RV_OPC_OP, 3'd7, b30_any};
      OP_ADDIW:   e = '{FMT_I, `RV_OPC_OPIMM32, 3'd0, b30_any};
      OP_SLLIW:   e = '{FMT_I, `RV_OPC_OPIMM32, 3'd1, b30_any};
      OP_SRLIW:   e = '{FMT_I, `RV_OPC_OPIMM32, 3'd5, 2'd0};
      OP_SRAIW:   e = '{FMT_I, `RV_OPC_OPIMM32, 3'd5, 2'd1};
      OP_ADDW:    e = '{FMT_R, `RV_OPC_OP32, 3'd0, 2'd0};
      OP_SUBW:    e = '{FMT_R, `RV_OPC_OP32, 3'd0, 2'd1};
      OP_SLLW:    e = '{FMT_R, `RV_OPC_OP32, 3'd1, b30_any};
      OP_SRLW:    e = '{FMT_R, `RV_OPC_OP32, 3'd5, 2'd0};
      OP_SRAW:    e = '{FMT_R, `RV_OPC_OP32, 3'd5, 2'd1};
      OP_FENCE:   e = '{FMT_NONE, `RV_OPC_MISCMEM, 3'd0, b30_any};
      OP_FENCE_I: e = '{FMT_NONE, `RV_OPC_MISCMEM, 3'd1, b30_any};
      OP_ECALL:   e = '{FMT_NONE, `RV_OPC_SYSTEM, 3'd0, b30_any};
      OP_EBREAK:  e = '{FMT_NONE, `RV_OPC_SYSTEM, 3'd0, b30_any};
      OP_MRET:    e = '{FMT_NONE, `RV_OPC_SYSTEM, 3'd0, b30_any};
      OP_CSRRW:   e = '{FMT_I, `RV_OPC_SYSTEM, 3'd1, b30_any};
      OP_CSRRS:   e = '{FMT_I, `RV_OPC_SYSTEM, 3'd2, b30_any};
      OP_CSRRC:   e = '{FMT_I, `RV_OPC_SYSTEM, 3'd3, b30_any};
      OP_CSRRWI:  e = '{FMT_CSRI, `RV_OPC_SYSTEM, 3'd5, b30_any};
      OP_CSRRSI:  e = '{FMT_CSRI, `RV_OPC_SYSTEM, 3'd6, b30_any};
      OP_CSRRCI:  e = '{FMT_CSRI, `RV_OPC_SYSTEM, 3'd7, b30_any};
      default:    e = '{FMT_NONE, 7'h7f, 3'd0, b30_any};
    endcase
    return e;
  endfunction

  // random word for a random kept instruction, or an illegal one
  task automatic gen_inst(output logic [`RV_ILEN-1:0] inst, output rv_op_e op,
                          output rv_fmt_e fmt);
    enc_t e;
    inst = $urandom;
    if ($urandom_range(0, 9) == 0) begin
      op  = OP_NONE;
      fmt = FMT_NONE;
      case ($urandom_range(0, 2))
        0: inst[6:0] = 7'h7f;
        1: begin
          inst[6:0]   = `RV_OPC_BRANCH;
          inst[14:12] = 3'b010;
        end
        default: begin
          inst[6:0]   = `RV_OPC_OPIMM32;
          inst[14:12] = 3'b011;
        end
      endcase
    end else begin
      op  = rv_op_e'($urandom_range(int'(OP_LUI), int'(OP_CSRRCI)));
      e   = op_encoding(op);
      fmt = e.fmt;
      inst[6:0] = e.opc;
      // U and J keep bits 14:12 as immediate
      if (!(fmt inside {FMT_U, FMT_J})) begin
        inst[14:12] = e.f3;
      end
      if (e.b30 != b30_any) begin
        inst[30] = e.b30[0];
      end
      case (op)
        OP_ECALL:  inst[31:20] = 12'h000;
        OP_EBREAK: inst[31:20] = 12'h001;
        OP_MRET:   inst[31:20] = 12'h302;
        default: ;
      endcase
    end
  endtask

  // expected result from the stage rules
  function automatic rv_exec_t model_exec(input logic [`RV_ILEN-1:0] inst, input rv_op_e op,
                                          input rv_fmt_e fmt, input logic [`RV_XLEN-1:0] pc,
                                          input logic [`RV_XLEN-1:0] rs1d,
                                          input logic [`RV_XLEN-1:0] rs2d);
    rv_exec_t x;
    logic signed [`RV_XLEN-1:0] imm_i;
    logic signed [`RV_XLEN-1:0] imm_s;
    logic signed [`RV_XLEN-1:0] imm_b;
    logic signed [`RV_XLEN-1:0] imm_u;
    logic signed [`RV_XLEN-1:0] imm_j;
    logic shift_imm;
    logic load;
    imm_i = $signed(inst[31:20]);
    imm_s = $signed({inst[31:25], inst[11:7]});
    imm_b = $signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0});
    imm_u = $signed({inst[31:12], 12'b0});
    imm_j = $signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0});
    shift_imm = op inside {OP_SLLI, OP_SRLI, OP_SRAI, OP_SLLIW, OP_SRLIW, OP_SRAIW};
    load = op inside {OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU};
    x = '0;
    x.op      = op;
    x.fmt     = fmt;
    x.rs1_ren = fmt inside {FMT_R, FMT_I, FMT_S, FMT_B};
    x.rs2_ren = fmt inside {FMT_R, FMT_S, FMT_B};
    x.rd_wen  = fmt inside {FMT_R, FMT_I, FMT_U, FMT_J, FMT_CSRI};
    x.rs1 = x.rs1_ren ? inst[19:15] : 5'd0;
    x.rs2 = x.rs2_ren ? inst[24:20] : 5'd0;
    x.rd  = x.rd_wen ? inst[11:7] : 5'd0;
    case (fmt)
      FMT_R: begin
        x.op1 = rs1d;
        x.op2 = rs2d;
      end
      FMT_I: begin
        x.op1 = rs1d;
        x.op2 = shift_imm ? {58'd0, inst[25:20]} : imm_i;
        if (op == OP_JALR) begin
          x.op3 = pc + 64'd4;
        end else if (load) begin
          x.op3 = imm_i;
        end
      end
      FMT_S: begin
        x.op1 = rs1d;
        x.op2 = rs2d;
        x.op3 = imm_s;
      end
      FMT_B: begin
        x.op1 = rs1d;
        x.op2 = rs2d;
        x.op3 = pc + imm_b;
      end
      FMT_U: begin
        x.op1 = imm_u;
        x.op2 = pc;
      end
      FMT_J: begin
        x.op1 = pc;
        x.op2 = 64'd4;
        x.op3 = pc + imm_j;
      end
      FMT_CSRI: x.op1 = {59'd0, inst[19:15]};
      default: ;
    endcase
    return x;
  endfunction

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      $display("[FAIL] time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
      $display("Done: errors found");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // compare DUT output with the expectation from the previous cycle
  task automatic compare_outputs();
    check_val("o_valid", pend_v, o_valid);
    if (pend_v) begin
      check_val("o_exec.op", pend.op, o_exec.op);
      check_val("o_exec.fmt", pend.fmt, o_exec.fmt);
      check_val("o_exec.rs1_ren", pend.rs1_ren, o_exec.rs1_ren);
      check_val("o_exec.rs1", pend.rs1, o_exec.rs1);
      check_val("o_exec.rs2_ren", pend.rs2_ren, o_exec.rs2_ren);
      check_val("o_exec.rs2", pend.rs2, o_exec.rs2);
      check_val("o_exec.rd_wen", pend.rd_wen, o_exec.rd_wen);
      check_val("o_exec.rd", pend.rd, o_exec.rd);
      check_val("o_exec.op1", pend.op1, o_exec.op1);
      check_val("o_exec.op2", pend.op2, o_exec.op2);
      check_val("o_exec.op3", pend.op3, o_exec.op3);
    end
  endtask

  task automatic drive_next();
    logic [`RV_ILEN-1:0] inst;
    rv_op_e              op;
    rv_fmt_e             fmt;
    logic                v;
    gen_inst(inst, op, fmt);
    v = ($urandom_range(0, 3) != 0);
    i_valid    = v;
    i_inst     = inst;
    i_pc       = {$urandom, $urandom};
    i_rs1_data = {$urandom, $urandom};
    i_rs2_data = {$urandom, $urandom};
    pend_v = v;
    if (v) begin
      pend = model_exec(inst, op, fmt, i_pc, i_rs1_data, i_rs2_data);
    end
  endtask

  initial begin
    void'($urandom(80420));
    rst        = 1'b1;
    i_valid    = 1'b0;
    i_inst     = '0;
    i_pc       = '0;
    i_rs1_data = '0;
    i_rs2_data = '0;
    pend_v     = 1'b0;
    pend       = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int n = 0; n < n_tests; n++) begin
      compare_outputs();
      drive_next();
      @(negedge clk);
    end
    compare_outputs();
    if (dut0.u_asserts.fail_cnt == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("Done: errors found");
      $fatal(1, "bound assertions reported failures");
    end
  end

  // reset, one cycle per test, plus margin
  initial begin
    #(n_tests * 100 + 300 + 1000);
    $display("watchdog: the run timed out before all tests finished");
    $display("Done: errors found");
    $fatal(1, "timeout");
  end

endmodule

/* rv_decode_asserts.sv */
/* concurrent checks on the decode stage top, attached with bind
   covers reset of the valid bit, one-cycle latency and index gating */
module rv_decode_asserts
  import rv_decode_pkg::*;
(
  input logic     clk,
  input logic     rst,
  input logic     i_valid,
  input logic     o_valid,
  input rv_exec_t o_exec
);

  // number of failed assertions so far
  int fail_cnt = 0;

  a_reset_clears: assert property (@(posedge clk) rst |=> !o_valid)
    else begin
      fail_cnt++;
      $error("o_valid not low in the cycle after reset");
    end

  a_valid_follows: assert property (@(posedge clk) disable iff (rst)
    !$past(rst) |-> o_valid == $past(i_valid))
    else begin
      fail_cnt++;
      $error("o_valid does not follow i_valid by one cycle");
    end

  // a clear enable must come with a zero index
  a_idx_gated: assert property (@(posedge clk) disable iff (rst)
    o_valid |-> (o_exec.rs1_ren || o_exec.rs1 == '0) &&
                (o_exec.rs2_ren || o_exec.rs2 == '0) &&
                (o_exec.rd_wen || o_exec.rd == '0))
    else begin
      fail_cnt++;
      $error("register index not zero while its enable is clear");
    end

endmodule

bind rv_decode_stage rv_decode_asserts u_asserts (.*);

/* rv_decode_stage.sv */
/* decode stage top: classify, register, then build operands
   each valid instruction comes out exactly one clock after it is sampled */
`include "rv_defines.svh"

module rv_decode_stage
  import rv_decode_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                i_valid,
  input  logic [`RV_ILEN-1:0] i_inst,
  input  logic [`RV_XLEN-1:0] i_pc,
  input  logic [`RV_XLEN-1:0] i_rs1_data,
  input  logic [`RV_XLEN-1:0] i_rs2_data,
  output logic                o_valid,
  output rv_exec_t            o_exec
);

  rv_dec_t dec_d;
  rv_dec_t dec_q;

  rv_inst_decoder u_decoder (
    .i_inst     (i_inst),
    .i_pc       (i_pc),
    .i_rs1_data (i_rs1_data),
    .i_rs2_data (i_rs2_data),
    .o_dec      (dec_d)
  );

  rv_id_ex_reg u_id_ex (
    .clk     (clk),
    .rst     (rst),
    .i_valid (i_valid),
    .i_dec   (dec_d),
    .o_valid (o_valid),
    .o_dec   (dec_q)
  );

  rv_operand_builder u_builder (
    .i_dec  (dec_q),
    .o_exec (o_exec)
  );

endmodule

/* rv_operand_builder.sv */
/* forms register enables, gated indices and the three execute operands
   from a held decoded item, purely combinational */
`include "rv_defines.svh"

module rv_operand_builder
  import rv_isa_pkg::*;
  import rv_decode_pkg::*;
(
  input  rv_dec_t  i_dec,
  output rv_exec_t o_exec
);

  logic rs1_ren;
  logic rs2_ren;
  logic rd_wen;
  logic is_shift_imm;
  logic is_load;

  assign rs1_ren = i_dec.fmt inside {FMT_R, FMT_I, FMT_S, FMT_B};
  assign rs2_ren = i_dec.fmt inside {FMT_R, FMT_S, FMT_B};
  assign rd_wen  = i_dec.fmt inside {FMT_R, FMT_I, FMT_U, FMT_J, FMT_CSRI};

  assign is_shift_imm = i_dec.op inside {OP_SLLI, OP_SRLI, OP_SRAI,
                                         OP_SLLIW, OP_SRLIW, OP_SRAIW};
  assign is_load      = i_dec.op inside {OP_LB, OP_LH, OP_LW, OP_LD,
                                         OP_LBU, OP_LHU, OP_LWU};

  always_comb begin
    o_exec.op      = i_dec.op;
    o_exec.fmt     = i_dec.fmt;
    o_exec.rs1_ren = rs1_ren;
    o_exec.rs2_ren = rs2_ren;
    o_exec.rd_wen  = rd_wen;
    o_exec.rs1     = rs1_ren ? i_dec.rs1 : '0;
    o_exec.rs2     = rs2_ren ? i_dec.rs2 : '0;
    o_exec.rd      = rd_wen ? i_dec.rd : '0;

    case (i_dec.fmt)
      FMT_R, FMT_I, FMT_S, FMT_B: o_exec.op1 = i_dec.rs1_data;
      FMT_U:    o_exec.op1 = i_dec.imm_u;
      FMT_J:    o_exec.op1 = i_dec.pc;
      // the rs1 field is the csr immediate here
      FMT_CSRI: o_exec.op1 = {{(`RV_XLEN-`RV_RIDX_W){1'b0}}, i_dec.rs1};
      default:  o_exec.op1 = '0;
    endcase

    case (i_dec.fmt)
      FMT_R, FMT_S, FMT_B: o_exec.op2 = i_dec.rs2_data;
      FMT_J:   o_exec.op2 = `RV_XLEN'(`RV_PC_STEP);
      FMT_I:   o_exec.op2 = is_shift_imm ? {{(`RV_XLEN-6){1'b0}}, i_dec.shamt} : i_dec.imm_i;
      FMT_U:   o_exec.op2 = i_dec.pc;
      default: o_exec.op2 = '0;
    endcase

    // branch and jump targets, store offset, jalr link address
    case (i_dec.fmt)
      FMT_B: o_exec.op3 = i_dec.pc + i_dec.imm_b;
      FMT_J: o_exec.op3 = i_dec.pc + i_dec.imm_j;
      FMT_S: o_exec.op3 = i_dec.imm_s;
      FMT_I: begin
        if (i_dec.op == OP_JALR) begin
          o_exec.op3 = i_dec.pc + `RV_XLEN'(`RV_PC_STEP);
        end else if (is_load) begin
          o_exec.op3 = i_dec.imm_i;
        end else begin
          o_exec.op3 = '0;
        end
      end
      default: o_exec.op3 = '0;
    endcase
  end

endmodule

/* rv_id_ex_reg.sv */
/* decode-to-execute pipeline register, one item deep
   payload loads on a valid strobe, the valid bit follows every cycle */
module rv_id_ex_reg
  import rv_decode_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    i_valid,
  input  rv_dec_t i_dec,
  output logic    o_valid,
  output rv_dec_t o_dec
);

  always_ff @(posedge clk) begin
    if (rst) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

  // held item is stale once o_valid drops
  always_ff @(posedge clk) begin
    if (i_valid) begin
      o_dec <= i_dec;
    end
  end

endmodule

/* rv_inst_decoder.sv */
/* combinational instruction classifier: fields, immediates, opcode enum
   and format, bundled with pc and register data for the ID/EX register */
`include "rv_defines.svh"

module rv_inst_decoder
  import rv_isa_pkg::*;
  import rv_decode_pkg::*;
(
  input  logic [`RV_ILEN-1:0] i_inst,
  input  logic [`RV_XLEN-1:0] i_pc,
  input  logic [`RV_XLEN-1:0] i_rs1_data,
  input  logic [`RV_XLEN-1:0] i_rs2_data,
  output rv_dec_t             o_dec
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic        f7_b5;
  logic [11:0] funct12;
  rv_op_e      op;
  rv_fmt_e     fmt;

  assign opcode  = i_inst[6:0];
  assign funct3  = i_inst[14:12];
  assign f7_b5   = i_inst[30];
  assign funct12 = i_inst[31:20];

  always_comb begin
    op = OP_NONE;
    case (opcode)
      `RV_OPC_LUI:   op = OP_LUI;
      `RV_OPC_AUIPC: op = OP_AUIPC;
      `RV_OPC_JAL:   op = OP_JAL;
      `RV_OPC_JALR:  if (funct3 == 3'b000) op = OP_JALR;
      `RV_OPC_BRANCH: begin
        case (funct3)
          3'b000: op = OP_BEQ;
          3'b001: op = OP_BNE;
          3'b100: op = OP_BLT;
          3'b101: op = OP_BGE;
          3'b110: op = OP_BLTU;
          3'b111: op = OP_BGEU;
          default: op = OP_NONE;
        endcase
      end
      `RV_OPC_LOAD: begin
        case (funct3)
          3'b000: op = OP_LB;
          3'b001: op = OP_LH;
          3'b010: op = OP_LW;
          3'b011: op = OP_LD;
          3'b100: op = OP_LBU;
          3'b101: op = OP_LHU;
          3'b110: op = OP_LWU;
          default: op = OP_NONE;
        endcase
      end
      `RV_OPC_STORE: begin
        case (funct3)
          3'b000: op = OP_SB;
          3'b001: op = OP_SH;
          3'b010: op = OP_SW;
          3'b011: op = OP_SD;
          default: op = OP_NONE;
        endcase
      end
      `RV_OPC_OPIMM: begin
        case (funct3)
          3'b000: op = OP_ADDI;
          3'b001: op = OP_SLLI;
          3'b010: op = OP_SLTI;
          3'b011: op = OP_SLTIU;
          3'b100: op = OP_XORI;
          3'b101: op = f7_b5 ? OP_SRAI : OP_SRLI;
          3'b110: op = OP_ORI;
          default: op = OP_ANDI;
        endcase
      end
      `RV_OPC_OP: begin
        case (funct3)
          3'b000: op = f7_b5 ? OP_SUB : OP_ADD;
          3'b001: op = OP_SLL;
          3'b010: op = OP_SLT;
          3'b011: op = OP_SLTU;
          3'b100: op = OP_XOR;
          3'b101: op = f7_b5 ? OP_SRA : OP_SRL;
          3'b110: op = OP_OR;
          default: op = OP_AND;
        endcase
      end
      `RV_OPC_OPIMM32: begin
        case (funct3)
          3'b000: op = OP_ADDIW;
          3'b001: op = OP_SLLIW;
          3'b101: op = f7_b5 ? OP_SRAIW : OP_SRLIW;
          default: op = OP_NONE;
        endcase
      end
      `RV_OPC_OP32: begin
        case (funct3)
          3'b000: op = f7_b5 ? OP_SUBW : OP_ADDW;
          3'b001: op = OP_SLLW;
          3'b101: op = f7_b5 ? OP_SRAW : OP_SRLW;
          default: op = OP_NONE;
        endcase
      end
      `RV_OPC_MISCMEM: begin
        if (funct3 == 3'b000) op = OP_FENCE;
        else if (funct3 == 3'b001) op = OP_FENCE_I;
      end
      `RV_OPC_SYSTEM: begin
        case (funct3)
          3'b000: begin
            // privileged ops differ only in funct12
            if (funct12 == 12'h000) op = OP_ECALL;
            else if (funct12 == 12'h001) op = OP_EBREAK;
            else if (funct12 == 12'h302) op = OP_MRET;
          end
          3'b001: op = OP_CSRRW;
          3'b010: op = OP_CSRRS;
          3'b011: op = OP_CSRRC;
          3'b101: op = OP_CSRRWI;
          3'b110: op = OP_CSRRSI;
          3'b111: op = OP_CSRRCI;
          default: op = OP_NONE;
        endcase
      end
      default: op = OP_NONE;
    endcase
  end

  // fence and the privileged ops carry no register or operand format
  always_comb begin
    case (op)
      OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU, OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
      OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW:                    fmt = FMT_R;
      OP_JALR, OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU,
      OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
      OP_SLLI, OP_SRLI, OP_SRAI, OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW,
      OP_CSRRW, OP_CSRRS, OP_CSRRC:                                   fmt = FMT_I;
      OP_SB, OP_SH, OP_SW, OP_SD:                                     fmt = FMT_S;
      OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU:               fmt = FMT_B;
      OP_LUI, OP_AUIPC:                                               fmt = FMT_U;
      OP_JAL:                                                         fmt = FMT_J;
      OP_CSRRWI, OP_CSRRSI, OP_CSRRCI:                                fmt = FMT_CSRI;
      default:                                                        fmt = FMT_NONE;
    endcase
  end

  always_comb begin
    o_dec.op       = op;
    o_dec.fmt      = fmt;
    o_dec.rs1      = i_inst[19:15];
    o_dec.rs2      = i_inst[24:20];
    o_dec.rd       = i_inst[11:7];
    o_dec.shamt    = i_inst[25:20];
    o_dec.imm_i    = {{(`RV_XLEN-12){i_inst[31]}}, i_inst[31:20]};
    o_dec.imm_s    = {{(`RV_XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    o_dec.imm_b    = {{(`RV_XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7],
                      i_inst[30:25], i_inst[11:8], 1'b0};
    o_dec.imm_u    = {{(`RV_XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
    o_dec.imm_j    = {{(`RV_XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12],
                      i_inst[20], i_inst[30:21], 1'b0};
    o_dec.pc       = i_pc;
    o_dec.rs1_data = i_rs1_data;
    o_dec.rs2_data = i_rs2_data;
  end

endmodule

/* rv_decode_pkg.sv */
/* structs that travel between the decode stage blocks: the raw decoded
   item before the ID/EX register and the finished result after it */
`include "rv_defines.svh"

package rv_decode_pkg;

  import rv_isa_pkg::*;

  typedef struct packed {
    rv_op_e                 op;
    rv_fmt_e                fmt;
    logic [`RV_RIDX_W-1:0]  rs1;
    logic [`RV_RIDX_W-1:0]  rs2;
    logic [`RV_RIDX_W-1:0]  rd;
    logic [5:0]             shamt;
    logic [`RV_XLEN-1:0]    imm_i;
    logic [`RV_XLEN-1:0]    imm_s;
    logic [`RV_XLEN-1:0]    imm_b;
    logic [`RV_XLEN-1:0]    imm_u;
    logic [`RV_XLEN-1:0]    imm_j;
    logic [`RV_XLEN-1:0]    pc;
    logic [`RV_XLEN-1:0]    rs1_data;
    logic [`RV_XLEN-1:0]    rs2_data;
  } rv_dec_t;

  typedef struct packed {
    rv_op_e                 op;
    rv_fmt_e                fmt;
    logic                   rs1_ren;
    logic [`RV_RIDX_W-1:0]  rs1;
    logic                   rs2_ren;
    logic [`RV_RIDX_W-1:0]  rs2;
    logic                   rd_wen;
    logic [`RV_RIDX_W-1:0]  rd;
    logic [`RV_XLEN-1:0]    op1;
    logic [`RV_XLEN-1:0]    op2;
    logic [`RV_XLEN-1:0]    op3;
  } rv_exec_t;

endpackage

/* rv_isa_pkg.sv */
/* ISA-level types: one opcode value per decoded instruction and the
   encoding format that selects registers and operands */
package rv_isa_pkg;

  typedef enum logic [6:0] {
    OP_NONE,
    // upper immediate and jumps
    OP_LUI,
    OP_AUIPC,
    OP_JAL,
    OP_JALR,
    // branches
    OP_BEQ,
    OP_BNE,
    OP_BLT,
    OP_BGE,
    OP_BLTU,
    OP_BGEU,
    // loads and stores
    OP_LB, OP_LH, OP_LW, OP_LD,
    OP_LBU, OP_LHU, OP_LWU,
    OP_SB, OP_SH, OP_SW, OP_SD,
    // register-immediate
    OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
    OP_SLLI, OP_SRLI, OP_SRAI,
    // register-register
    OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
    OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
    // 32-bit word ops
    OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW,
    OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW,
    // memory ordering and system
    OP_FENCE,
    OP_FENCE_I,
    OP_ECALL,
    OP_EBREAK,
    OP_MRET,
    // Zicsr
    OP_CSRRW, OP_CSRRS, OP_CSRRC,
    OP_CSRRWI, OP_CSRRSI, OP_CSRRCI
  } rv_op_e;

  typedef enum logic [2:0] {
    FMT_NONE,
    FMT_R,
    FMT_I,
    FMT_S,
    FMT_B,
    FMT_U,
    FMT_J,
    // csr with 5-bit immediate in the rs1 field
    FMT_CSRI
  } rv_fmt_e;

endpackage

/* rv_defines.svh */
/* shared widths and RV64I major opcode values for the decode stage
   include in any file that sizes ports or matches opcodes */
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

`define RV_XLEN      64
`define RV_ILEN      32
`define RV_RIDX_W    5

// major opcodes, inst[6:0]
`define RV_OPC_LOAD      7'b0000011
`define RV_OPC_STORE     7'b0100011
`define RV_OPC_BRANCH    7'b1100011
`define RV_OPC_JAL       7'b1101111
`define RV_OPC_JALR      7'b1100111
`define RV_OPC_LUI       7'b0110111
`define RV_OPC_AUIPC     7'b0010111
`define RV_OPC_OPIMM     7'b0010011
`define RV_OPC_OPIMM32   7'b0011011
`define RV_OPC_OP        7'b0110011
`define RV_OPC_OP32      7'b0111011
`define RV_OPC_MISCMEM   7'b0001111
`define RV_OPC_SYSTEM    7'b1110011

`define RV_PC_STEP   4

`endif
